// File: decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_pipe_pkg::if_id_t  if_id,
    input  rv_pipe_pkg::id_ex_t  stall_src,
    input  logic                 redirect,
    input  rv_pipe_pkg::mem_wb_t mem_wb,
    output rv_pipe_pkg::id_ex_t  id_ex,
    output logic                 stall
);
    import rv_pipe_pkg::*;

    logic [31:0] regs [32];
    logic [31:0] inst;
    logic        known;
    logic [2:0]  raw_f3;
    logic [6:0]  raw_f7;
    opcode_e     opcode;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic        wb_we;
    logic        uses_rs2;
    id_ex_t      id_next;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  alu_sel = sub ? ALU_SUB : ALU_ADD;
            3'b010:  alu_sel = ALU_SLT;
            3'b100:  alu_sel = ALU_XOR;
            3'b110:  alu_sel = ALU_OR;
            3'b111:  alu_sel = ALU_AND;
            default: alu_sel = ALU_ADD;
        endcase
    endfunction

    assign raw_f3 = if_id.inst[14:12];
    assign raw_f7 = if_id.inst[31:25];

    // Anything outside the subset runs as a nop
    always_comb begin
        case (if_id.inst[6:0])
            OP:          known = (raw_f7 == 7'b0000000 &&
                                  raw_f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111}) ||
                                 (raw_f7 == 7'b0100000 && raw_f3 == 3'b000);
            OP_IMM:      known = raw_f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
            LOAD, STORE: known = raw_f3 == 3'b010;
            BRANCH:      known = raw_f3 inside {3'b000, 3'b001};
            default:     known = 1'b0;
        endcase
    end

    assign inst   = known ? if_id.inst : NOP_INST;
    assign opcode = opcode_e'(inst[6:0]);
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // Register file write port skips x0
    assign wb_we = mem_wb.valid && mem_wb.reg_write && mem_wb.rd != 5'd0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[mem_wb.rd] <= mem_wb.wb_data;
        end
    end

    always_comb begin
        id_next       = '0;
        id_next.valid = if_id.valid;
        id_next.pc    = if_id.pc;
        id_next.rs1   = rs1;
        id_next.rs2   = rs2;
        id_next.rd    = inst[11:7];
        // Same-cycle write-back bypasses the array
        id_next.rs1_data = (rs1 == 5'd0) ? '0 :
                           (wb_we && mem_wb.rd == rs1) ? mem_wb.wb_data : regs[rs1];
        id_next.rs2_data = (rs2 == 5'd0) ? '0 :
                           (wb_we && mem_wb.rd == rs2) ? mem_wb.wb_data : regs[rs2];
        id_next.alu_op = ALU_ADD;
        case (opcode)
            OP: begin
                id_next.reg_write = 1'b1;
                id_next.alu_op    = alu_sel(inst[14:12], inst[30]);
            end
            OP_IMM: begin
                id_next.reg_write = 1'b1;
                id_next.use_imm   = 1'b1;
                id_next.imm       = imm_i;
                id_next.alu_op    = alu_sel(inst[14:12], 1'b0);
            end
            LOAD: begin
                id_next.reg_write = 1'b1;
                id_next.mem_read  = 1'b1;
                id_next.use_imm   = 1'b1;
                id_next.imm       = imm_i;
            end
            STORE: begin
                id_next.mem_write = 1'b1;
                id_next.use_imm   = 1'b1;
                id_next.imm       = imm_s;
            end
            BRANCH: begin
                id_next.is_branch = 1'b1;
                id_next.branch_ne = inst[12];
                id_next.imm       = imm_b;
                id_next.alu_op    = ALU_SUB;
            end
            default: ;
        endcase
        if (!id_next.reg_write) begin
            id_next.rd = 5'd0;
        end
    end

    // Load in ID/EX feeding the instruction in decode
    assign uses_rs2 = opcode inside {OP, STORE, BRANCH};
    assign stall = if_id.valid && stall_src.valid && stall_src.mem_read &&
                   stall_src.rd != 5'd0 &&
                   (stall_src.rd == rs1 || (uses_rs2 && stall_src.rd == rs2));

    always_ff @(posedge clk) begin
        if (reset || redirect || stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_next;
        end
    end

    a_stall_keeps_if_id: assert property (
        @(posedge clk) disable iff (reset) stall |=> $stable(if_id)
    ) else $error("IF/ID changed during a load-use stall");

    a_redirect_clears_if_id: assert property (
        @(posedge clk) disable iff (reset) redirect |=> !if_id.valid
    ) else $error("IF/ID still valid after a branch redirect");

endmodule

`default_nettype wire

// File: execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_pipe_pkg::id_ex_t  id_ex,
    input  rv_pipe_pkg::mem_wb_t mem_wb,
    output rv_pipe_pkg::ex_mem_t ex_mem,
    output logic                 redirect,
    output logic [31:0]          redirect_pc
);
    import rv_pipe_pkg::*;

    logic        exm_fwd;
    logic        wb_fwd;
    logic [31:0] op_a;
    logic [31:0] rs2_val;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic        equal;
    ex_mem_t     ex_next;

    // A load in EX/MEM has no data yet, the stall covers it
    assign exm_fwd = ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read &&
                     ex_mem.rd != 5'd0;
    assign wb_fwd  = mem_wb.valid && mem_wb.reg_write && mem_wb.rd != 5'd0;

    // Youngest producer first
    always_comb begin
        op_a = id_ex.rs1_data;
        if (exm_fwd && ex_mem.rd == id_ex.rs1) begin
            op_a = ex_mem.alu_result;
        end else if (wb_fwd && mem_wb.rd == id_ex.rs1) begin
            op_a = mem_wb.wb_data;
        end
        rs2_val = id_ex.rs2_data;
        if (exm_fwd && ex_mem.rd == id_ex.rs2) begin
            rs2_val = ex_mem.alu_result;
        end else if (wb_fwd && mem_wb.rd == id_ex.rs2) begin
            rs2_val = mem_wb.wb_data;
        end
    end

    assign op_b = id_ex.use_imm ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            default: alu_out = op_a + op_b;
        endcase
    end

    // Branch resolution, predicted not taken
    assign equal       = op_a == rs2_val;
    assign redirect    = id_ex.valid && id_ex.is_branch && (id_ex.branch_ne ? !equal : equal);
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_comb begin
        ex_next.valid      = id_ex.valid;
        ex_next.pc         = id_ex.pc;
        ex_next.rd         = id_ex.rd;
        ex_next.alu_result = alu_out;
        ex_next.store_data = rs2_val;
        ex_next.reg_write  = id_ex.reg_write;
        ex_next.mem_read   = id_ex.mem_read;
        ex_next.mem_write  = id_ex.mem_write;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_next;
        end
    end

    a_alu_op_defined: assert property (
        @(posedge clk) disable iff (reset)
        id_ex.valid |-> id_ex.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT}
    ) else $error("undefined ALU operation from decode");

endmodule

`default_nettype wire

// File: fetch_stage.sv
`default_nettype none

module fetch_stage #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  logic                stall,
    input  logic                redirect,
    input  logic [31:0]         redirect_pc,
    input  logic                imem_we,
    input  logic [31:0]         imem_addr,
    input  logic [31:0]         imem_data,
    output rv_pipe_pkg::if_id_t if_id
);
    import rv_pipe_pkg::*;

    localparam int IW = $clog2(IMEM_WORDS);

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] pc;
    logic [31:0] fetched;

    // Program load, byte address, only while stopped
    always_ff @(posedge clk) begin
        if (imem_we && !run) begin
            imem[imem_addr[IW+1:2]] <= imem_data;
        end
    end

    assign fetched = imem[pc[IW+1:2]];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= '0;
            if_id.valid <= 1'b0;
            if_id.inst  <= NOP_INST;
        end else if (redirect) begin
            // Taken branch wins over a stall
            pc          <= redirect_pc;
            if_id.valid <= 1'b0;
            if_id.inst  <= NOP_INST;
        end else if (!stall) begin
            if (run) begin
                pc    <= pc + 32'd4;
                if_id <= '{valid: 1'b1, pc: pc, inst: fetched};
            end else begin
                // Stopped, let the pipe drain
                if_id.valid <= 1'b0;
                if_id.inst  <= NOP_INST;
            end
        end
    end

    a_load_while_stopped: assert property (
        @(posedge clk) disable iff (reset) imem_we |-> !run
    ) else $error("instruction memory written while the core is running");

endmodule

`default_nettype wire

// File: memory_stage.sv
`default_nettype none

module memory_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_pipe_pkg::ex_mem_t ex_mem,
    output rv_pipe_pkg::mem_wb_t mem_wb,
    output logic                 retire_valid,
    output logic [31:0]          retire_pc,
    output logic                 retire_we,
    output logic [4:0]           retire_rd,
    output logic [31:0]          retire_data,
    output logic                 store_valid,
    output logic [31:0]          store_addr,
    output logic [31:0]          store_data
);
    import rv_pipe_pkg::*;

    localparam int DW = $clog2(DMEM_WORDS);

    logic [31:0]   dmem [DMEM_WORDS];
    logic [DW-1:0] dmem_idx;
    mem_wb_t       wb_next;

    // Word index, wraps modulo the memory size
    assign dmem_idx = ex_mem.alu_result[DW+1:2];

    always_ff @(posedge clk) begin
        if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[dmem_idx] <= ex_mem.store_data;
        end
    end

    assign store_valid = ex_mem.valid && ex_mem.mem_write;
    assign store_addr  = ex_mem.alu_result;
    assign store_data  = ex_mem.store_data;

    always_comb begin
        wb_next.valid     = ex_mem.valid;
        wb_next.pc        = ex_mem.pc;
        wb_next.rd        = ex_mem.rd;
        wb_next.wb_data   = ex_mem.mem_read ? dmem[dmem_idx] : ex_mem.alu_result;
        wb_next.reg_write = ex_mem.reg_write;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= wb_next;
        end
    end

    // One retire per instruction leaving write-back
    assign retire_valid = mem_wb.valid;
    assign retire_pc    = mem_wb.pc;
    assign retire_we    = mem_wb.reg_write && mem_wb.rd != 5'd0;
    assign retire_rd    = mem_wb.rd;
    assign retire_data  = mem_wb.wb_data;

    a_word_aligned: assert property (
        @(posedge clk) disable iff (reset)
        (ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write)) |-> ex_mem.alu_result[1:0] == 2'b00
    ) else $error("misaligned data memory access");

endmodule

`default_nettype wire

// File: rv_pipe.f
rv_pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
rv_pipe_top.sv
rv_pipe_tb.sv

// File: rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    // Major opcodes of the RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INST = {12'd0, 5'd0, 3'b000, 5'd0, OP_IMM};

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        alu_op_e     alu_op;
        logic        use_imm;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        is_branch;
        logic        branch_ne;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        // Also the byte address for lw and sw
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] wb_data;
        logic        reg_write;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: rv_pipe_tb.sv
`default_nettype none

module rv_pipe_tb;

    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } retire_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    localparam logic [6:0]  OPC_OP   = 7'b0110011;
    localparam logic [6:0]  OPC_IMM  = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD = 7'b0000011;
    // beq x0, x0, 0 parks the core after the last instruction
    localparam logic [31:0] HALT     = 32'h0000_0063;
    localparam int          TIMEOUT  = 2000;

    logic        clk;
    logic        reset;
    logic        run;
    logic        imem_we;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;

    logic [31:0] prog [$];
    retire_t     exp_ret [$];
    retire_t     got_ret [$];
    store_t      exp_st [$];
    store_t      got_st [$];
    logic [31:0] halt_pc;
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          tests;

    rv_pipe_top uut (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return i_type(OPC_IMM, 3'd0, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // funct3 values of the supported ALU operations
    function automatic logic alu_f3_ok(input logic [2:0] f3);
        return f3 == 3'd0 || f3 == 3'd2 || f3 == 3'd4 || f3 == 3'd6 || f3 == 3'd7;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, b);
        case (f3)
            3'd0:    return sub ? a - b : a + b;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd6:    return a | b;
            3'd7:    return a & b;
            default: return 32'd0;
        endcase
    endfunction

    function automatic int count_retired(input logic [31:0] pc);
        int n;
        n = 0;
        foreach (got_ret[i]) begin
            if (got_ret[i].pc == pc) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic reset_core();
        @(posedge clk);
        run     <= 1'b0;
        imem_we <= 1'b0;
        reset   <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic load_program();
        halt_pc = prog.size() * 4;
        // Two halt words so the wrong-path fetch after it is defined
        for (int i = 0; i < prog.size() + 2; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= i * 4;
            imem_data <= (i < prog.size()) ? prog[i] : HALT;
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    // ISA-level reference, one instruction at a time
    task automatic model();
        logic [31:0] regs [32];
        logic [31:0] mem [256];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] res;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic        wr;
        int          steps;
        exp_ret.delete();
        exp_st.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
        pc = '0;
        steps = 0;
        while (pc != halt_pc && pc[31:2] < prog.size() && steps < 500) begin
            inst  = prog[pc[31:2]];
            f3    = inst[14:12];
            f7    = inst[31:25];
            rd    = inst[11:7];
            a     = regs[inst[19:15]];
            b     = regs[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            npc   = pc + 32'd4;
            wr    = 1'b0;
            res   = '0;
            if (inst[6:0] == OPC_OP && ((f7 == 7'h00 && alu_f3_ok(f3)) ||
                                        (f7 == 7'h20 && f3 == 3'd0))) begin
                wr  = 1'b1;
                res = alu_ref(f3, f7[5], a, b);
            end else if (inst[6:0] == OPC_IMM && alu_f3_ok(f3)) begin
                wr  = 1'b1;
                res = alu_ref(f3, 1'b0, a, imm_i);
            end else if (inst[6:0] == OPC_LOAD && f3 == 3'd2) begin
                wr  = 1'b1;
                res = mem[(a + imm_i) >> 2 & 32'hff];
            end else if (inst[6:0] == 7'b0100011 && f3 == 3'd2) begin
                mem[(a + imm_s) >> 2 & 32'hff] = b;
                exp_st.push_back('{a + imm_s, b});
            end else if (inst[6:0] == 7'b1100011 && f3[2:1] == 2'b00) begin
                if ((a == b) != f3[0]) begin
                    npc = pc + imm_b;
                end
            end
            wr = wr && rd != 5'd0;
            if (wr) begin
                regs[rd] = res;
            end
            exp_ret.push_back('{pc, wr, wr ? rd : 5'd0, wr ? res : 32'd0});
            pc = npc;
            steps++;
        end
    endtask

    task automatic sample_ports();
        if (retire_valid && retire_pc != halt_pc) begin
            got_ret.push_back('{retire_pc, retire_we, retire_rd, retire_data});
        end
        if (store_valid) begin
            got_st.push_back('{store_addr, store_data});
        end
    endtask

    task automatic run_and_collect();
        int cycles;
        got_ret.delete();
        got_st.delete();
        @(posedge clk);
        run <= 1'b1;
        cycles = 0;
        while (got_ret.size() < exp_ret.size() && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            sample_ports();
        end
        if (got_ret.size() < exp_ret.size()) begin
            errors++;
            $display("Timeout: only %0d of %0d instructions retired within %0d cycles",
                     got_ret.size(), exp_ret.size(), TIMEOUT);
        end
        @(posedge clk);
        run <= 1'b0;
        // Anything extra retiring while draining shows up in the counts
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            sample_ports();
        end
    endtask

    task automatic compare_results();
        check(got_ret.size(), exp_ret.size(), "number of retired instructions");
        for (int i = 0; i < got_ret.size() && i < exp_ret.size(); i++) begin
            check(got_ret[i].pc, exp_ret[i].pc, $sformatf("retire %0d pc", i));
            check(got_ret[i].we, exp_ret[i].we, $sformatf("retire %0d we", i));
            if (exp_ret[i].we) begin
                check(got_ret[i].rd, exp_ret[i].rd, $sformatf("retire %0d rd", i));
                check(got_ret[i].data, exp_ret[i].data, $sformatf("retire %0d data", i));
            end
        end
        check(got_st.size(), exp_st.size(), "number of stores");
        for (int i = 0; i < got_st.size() && i < exp_st.size(); i++) begin
            check(got_st[i].addr, exp_st[i].addr, $sformatf("store %0d address", i));
            check(got_st[i].data, exp_st[i].data, $sformatf("store %0d data", i));
        end
    endtask

    task automatic run_program();
        reset_core();
        load_program();
        model();
        run_and_collect();
        compare_results();
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        $display("test %-12s %s", name, (errors == start) ? "passed" : "failed");
    endtask

    task automatic test_alu_chain();
        int start;
        start = errors;
        prog.delete();
        prog.push_back(addi(1, 0, 12'd100));
        prog.push_back(addi(2, 0, -12'sd7));
        prog.push_back(r_type(7'h00, 3'd0, 3, 1, 2));
        prog.push_back(r_type(7'h20, 3'd0, 4, 3, 1));
        prog.push_back(r_type(7'h00, 3'd7, 5, 4, 3));
        prog.push_back(r_type(7'h00, 3'd6, 6, 5, 2));
        prog.push_back(r_type(7'h00, 3'd4, 7, 6, 4));
        prog.push_back(r_type(7'h00, 3'd2, 8, 2, 1));
        prog.push_back(r_type(7'h00, 3'd2, 9, 1, 2));
        prog.push_back(i_type(OPC_IMM, 3'd7, 10, 7, 12'h0f0));
        prog.push_back(i_type(OPC_IMM, 3'd6, 11, 10, 12'hf00));
        prog.push_back(i_type(OPC_IMM, 3'd4, 12, 11, 12'h555));
        prog.push_back(i_type(OPC_IMM, 3'd2, 13, 2, -12'sd3));
        prog.push_back(r_type(7'h00, 3'd0, 14, 13, 12));
        run_program();
        report_test("alu_chain", start);
    endtask

    task automatic test_load_use();
        int start;
        start = errors;
        prog.delete();
        prog.push_back(addi(1, 0, 12'd64));
        prog.push_back(addi(2, 0, 12'd123));
        prog.push_back(sw(2, 1, 12'd0));
        prog.push_back(i_type(OPC_LOAD, 3'd2, 3, 1, 12'd0));
        prog.push_back(r_type(7'h00, 3'd0, 4, 3, 2));
        prog.push_back(sw(4, 1, 12'd4));
        prog.push_back(i_type(OPC_LOAD, 3'd2, 5, 1, 12'd4));
        prog.push_back(sw(5, 1, 12'd8));
        prog.push_back(i_type(OPC_LOAD, 3'd2, 6, 1, 12'd8));
        prog.push_back(addi(7, 6, 12'd1));
        run_program();
        report_test("load_use", start);
    endtask

    task automatic test_branches();
        int start;
        start = errors;
        prog.delete();
        prog.push_back(addi(1, 0, 12'd3));
        prog.push_back(addi(2, 0, 12'd3));
        prog.push_back(branch(3'd0, 1, 2, 13'd12));
        prog.push_back(addi(3, 0, 12'd1));
        prog.push_back(addi(4, 0, 12'd2));
        prog.push_back(addi(5, 0, 12'd7));
        prog.push_back(branch(3'd1, 1, 2, 13'd8));
        prog.push_back(addi(6, 0, 12'd9));
        prog.push_back(branch(3'd1, 5, 1, 13'd8));
        prog.push_back(addi(7, 0, 12'd11));
        prog.push_back(addi(8, 5, 12'd1));
        run_program();
        check(count_retired(32'd12), 0, "skipped pc 12 retired");
        check(count_retired(32'd16), 0, "skipped pc 16 retired");
        check(count_retired(32'd36), 0, "skipped pc 36 retired");
        check(count_retired(32'd28), 1, "fall-through pc 28 retired");
        report_test("branches", start);
    endtask

    task automatic test_x0();
        int start;
        start = errors;
        prog.delete();
        prog.push_back(addi(0, 0, 12'd55));
        prog.push_back(addi(1, 0, 12'd9));
        prog.push_back(r_type(7'h00, 3'd0, 0, 1, 1));
        prog.push_back(r_type(7'h00, 3'd0, 2, 0, 1));
        prog.push_back(i_type(OPC_IMM, 3'd6, 3, 0, 12'd0));
        run_program();
        if (got_ret.size() > 2) begin
            check(got_ret[0].we, 1'b0, "retire_we of addi x0");
            check(got_ret[2].we, 1'b0, "retire_we of add x0");
        end
        report_test("x0", start);
    endtask

    task automatic test_random();
        int          start;
        logic [31:0] r;
        int          sel;
        logic [2:0]  f3_tab [6];
        start = errors;
        f3_tab = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2};
        prog.delete();
        for (int i = 0; i < 40; i++) begin
            r = next_random();
            sel = r[7:4] % 11;
            // Eight registers keep the dependencies dense
            if (sel < 6) begin
                prog.push_back(r_type((sel == 1) ? 7'h20 : 7'h00, f3_tab[sel],
                                      r[10:8], r[13:11], r[16:14]));
            end else begin
                prog.push_back(i_type(OPC_IMM, f3_tab[sel - 5], r[10:8], r[13:11], r[31:20]));
            end
        end
        run_program();
        report_test("random", start);
    endtask

    task automatic test_unknown();
        int start;
        start = errors;
        prog.delete();
        prog.push_back(addi(1, 0, 12'd5));
        prog.push_back(32'hffff_ffff);
        prog.push_back(r_type(7'h00, 3'd0, 2, 1, 1));
        // mul and slli are outside the subset
        prog.push_back(r_type(7'h01, 3'd0, 1, 1, 1));
        prog.push_back(r_type(7'h00, 3'd0, 3, 1, 1));
        prog.push_back(i_type(OPC_IMM, 3'd1, 2, 2, 12'd1));
        prog.push_back(r_type(7'h20, 3'd0, 4, 3, 2));
        run_program();
        if (got_ret.size() > 3) begin
            check(got_ret[1].we, 1'b0, "retire_we of unknown encoding");
            check(got_ret[3].we, 1'b0, "retire_we of mul");
        end
        report_test("unknown", start);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        run       = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        rng_state = 32'h1a6c1a0b;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        test_alu_chain();
        test_load_use();
        test_branches();
        test_x0();
        test_random();
        test_unknown();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_pipe_top.sv
`default_nettype none

module rv_pipe_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        run,
    input  logic        imem_we,
    input  logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic        retire_we,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_data,
    output logic        store_valid,
    output logic [31:0] store_addr,
    output logic [31:0] store_data
);
    import rv_pipe_pkg::*;

    // Pipeline registers
    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    mem_wb_t     mem_wb;

    // Hazard and branch control
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;

    fetch_stage #(
        .IMEM_WORDS (IMEM_WORDS)
    ) fetch_stage (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .if_id       (if_id)
    );

    decode_stage decode_stage (
        .clk       (clk),
        .reset     (reset),
        .if_id     (if_id),
        .stall_src (id_ex),
        .redirect  (redirect),
        .mem_wb    (mem_wb),
        .id_ex     (id_ex),
        .stall     (stall)
    );

    execute_stage execute_stage (
        .clk         (clk),
        .reset       (reset),
        .id_ex       (id_ex),
        .mem_wb      (mem_wb),
        .ex_mem      (ex_mem),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) memory_stage (
        .clk          (clk),
        .reset        (reset),
        .ex_mem       (ex_mem),
        .mem_wb       (mem_wb),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data)
    );

endmodule

`default_nettype wire
